// ==== files.f ====
+incdir+design
design/ahb_pkg.sv
design/crc_pkg.sv
design/crc_host_interface.sv
design/crc_input_buffer.sv
design/crc_config_regs.sv
design/crc_engine.sv
design/crc_ahb_top.sv
sim/tb_crc_ahb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the CRC AHB-Lite testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f files.f --top-module tb_crc_ahb -o tb_crc_ahb > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_crc_ahb > sim.log 2>&1

grep -qx '>>> PASS' sim.log \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

// ==== sim/tb_crc_ahb.sv ====
// CRC unit testbench
// Drives the AHB-Lite port with single transfers and checks every
// DR result against a bit-serial reference model of the CRC rules
`timescale 1ns/100ps

module tb_crc_ahb;
	import ahb_pkg::*;

	// Register word indices
	localparam logic [2:0] IDX_DR   = 3'd0;
	localparam logic [2:0] IDX_IDR  = 3'd1;
	localparam logic [2:0] IDX_CR   = 3'd2;
	localparam logic [2:0] IDX_INIT = 3'd4;
	localparam logic [2:0] IDX_POL  = 3'd5;
	// Roughly 170 transfers at up to 9 cycles each, plus headroom
	localparam int MAX_CYCLES = 4000;

	logic        HCLK;
	logic        HRESETn;
	logic        hsel;
	logic [31:0] haddr;
	htrans_t     htrans;
	hsize_t      hsize;
	logic        hwrite;
	logic        hready;
	logic [31:0] hwdata;
	logic [31:0] hrdata;
	logic        hreadyout;
	logic        hresp;

	int          cycles = 0;
	int          stall_cycles = 0;
	int          test_errs = 0;
	int          errors = 0;
	int          tests_pass = 0;
	int          tests_fail = 0;
	logic [31:0] rng_state = 32'd90;
	// Reference model state and its copy of the configuration
	logic [31:0] model = 32'hFFFF_FFFF;
	logic [31:0] m_init = 32'hFFFF_FFFF;
	logic [31:0] m_poly = 32'h04C1_1DB7;
	logic [1:0]  m_psize = 2'd0;
	logic [1:0]  m_revin = 2'd0;
	logic        m_revout = 1'b0;

	crc_ahb_top uut (.HCLK, .HRESETn, .hsel, .haddr, .htrans, .hsize, .hwrite, .hready,
		.hwdata, .hrdata, .hreadyout, .hresp);

	always #4 HCLK = ~HCLK;

	// Run limit
	always @(posedge HCLK)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display(">>> FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic [7:0] rev8(input logic [7:0] b);
		logic [7:0] r;
		for (int i = 0; i < 8; i++)
			r[7 - i] = b[i];
		return r;
	endfunction

	function automatic logic [31:0] rev32(input logic [31:0] x);
		return {rev8(x[7:0]), rev8(x[15:8]), rev8(x[23:16]), rev8(x[31:24])};
	endfunction

	// 0 none, 1 within bytes, 2 within halfwords, 3 whole word
	function automatic logic [31:0] rev_input(input logic [31:0] d, input logic [1:0] mode);
		case (mode)
			2'd1:    return {rev8(d[31:24]), rev8(d[23:16]), rev8(d[15:8]), rev8(d[7:0])};
			2'd2:    return {rev8(d[23:16]), rev8(d[31:24]), rev8(d[7:0]), rev8(d[15:8])};
			2'd3:    return rev32(d);
			default: return d;
		endcase
	endfunction

	function automatic int width_of(input logic [1:0] psize);
		case (psize)
			2'd1:    return 16;
			2'd2:    return 8;
			2'd3:    return 7;
			default: return 32;
		endcase
	endfunction

	function automatic logic [31:0] wmask_of(input logic [1:0] psize);
		int w;
		w = width_of(psize);
		return (w == 32) ? 32'hFFFF_FFFF : ((32'h1 << w) - 32'h1);
	endfunction

	// Low bytes after reversal, highest byte first, each byte MSB first
	function automatic void model_feed(input logic [31:0] data, input logic [1:0] size);
		logic [31:0] d;
		logic [31:0] mask;
		logic [7:0]  b;
		logic        fb;
		int          w;
		int          nbytes;
		w      = width_of(m_psize);
		mask   = wmask_of(m_psize);
		d      = rev_input(data, m_revin);
		nbytes = (size == 2'd0) ? 1 : (size == 2'd1) ? 2 : 4;
		for (int k = nbytes - 1; k >= 0; k--)
		begin
			b = d[8 * k +: 8];
			for (int i = 7; i >= 0; i--)
			begin
				fb    = model[w - 1] ^ b[i];
				model = (model << 1) & mask;
				if (fb)
					model = model ^ (m_poly & mask);
			end
		end
	endfunction

	function automatic logic [31:0] model_out();
		return m_revout ? rev32(model) : model;
	endfunction

	////////////////////////////////////////////////////////////
	// Bus tasks and checks
	////////////////////////////////////////////////////////////
	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("ERROR at %0t ns: %s read %08h, expected %08h", $time, name, got, exp);
			test_errs++;
		end
	endtask

	// Address phase, then data phase held until hreadyout
	task automatic bus_xfer(input logic wr, input logic [2:0] idx, input logic [31:0] wdata,
		input logic [1:0] size, output logic [31:0] rdata);
		@(posedge HCLK);
		hsel   <= 1'b1;
		haddr  <= {27'h0, idx, 2'b00};
		htrans <= HTRANS_NONSEQ;
		hwrite <= wr;
		hsize  <= {1'b0, size};
		@(posedge HCLK);
		hsel   <= 1'b0;
		htrans <= HTRANS_IDLE;
		hwdata <= wdata;
		// Sample away from the clock edge
		@(negedge HCLK);
		while (!hreadyout)
		begin
			stall_cycles++;
			@(negedge HCLK);
		end
		rdata = hrdata;
		check_val("hresp", {31'h0, hresp}, 32'h0);
	endtask

	task automatic write_reg(input logic [2:0] idx, input logic [31:0] data,
		input logic [1:0] size = 2'd2);
		logic [31:0] unused;
		bus_xfer(1'b1, idx, data, size, unused);
	endtask

	task automatic read_reg(input logic [2:0] idx, output logic [31:0] data);
		bus_xfer(1'b0, idx, 32'h0, 2'd2, data);
	endtask

	// CR write with the reset bit, model reloads from INIT
	task automatic crc_reset(input logic [1:0] psize, input logic [1:0] revin,
		input logic revout);
		write_reg(IDX_CR, {24'h0, revout, revin, psize, 2'b00, 1'b1});
		m_psize  = psize;
		m_revin  = revin;
		m_revout = revout;
		model    = m_init & wmask_of(psize);
	endtask

	task automatic dr_write(input logic [31:0] data, input logic [1:0] size);
		write_reg(IDX_DR, data, size);
		model_feed(data, size);
	endtask

	task automatic check_reg(input string name, input logic [2:0] idx,
		input logic [31:0] exp);
		logic [31:0] got;
		read_reg(idx, got);
		check_val(name, got, exp);
	endtask

	task automatic finish_test(input string name);
		if (test_errs == 0)
		begin
			$display("Test %s: passed", name);
			tests_pass++;
		end
		else
		begin
			$display("Test %s: failed with %0d errors", name, test_errs);
			tests_fail++;
		end
		errors += test_errs;
		test_errs = 0;
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////
	task automatic reset_values();
		check_reg("INIT", IDX_INIT, 32'hFFFF_FFFF);
		check_reg("POL", IDX_POL, 32'h04C1_1DB7);
		check_reg("CR", IDX_CR, 32'h0);
		check_reg("IDR", IDX_IDR, 32'h0);
		check_reg("unmapped index 3", 3'd3, 32'h0);
		check_reg("unmapped index 7", 3'd7, 32'h0);
		finish_test("reset values");
	endtask

	task automatic register_access();
		logic [31:0] r;
		r = next_rand();
		write_reg(IDX_INIT, r);
		check_reg("INIT", IDX_INIT, r);
		r = next_rand();
		write_reg(IDX_POL, r);
		check_reg("POL", IDX_POL, r);
		r = next_rand();
		write_reg(IDX_IDR, r);
		check_reg("IDR", IDX_IDR, {24'h0, r[7:0]});
		// Bits 2:1 and 31:8 hold nothing, bit 0 reads back clear
		write_reg(IDX_CR, 32'hFFFF_FF6F);
		check_reg("CR", IDX_CR, 32'h0000_0068);
		// Back to defaults for the CRC tests
		write_reg(IDX_INIT, m_init);
		write_reg(IDX_POL, m_poly);
		crc_reset(2'd0, 2'd0, 1'b0);
		finish_test("register access");
	endtask

	task automatic default_crc32();
		logic [31:0] got;
		crc_reset(2'd0, 2'd0, 1'b0);
		// "123456789" as bytes, published CRC-32/MPEG-2 check value
		for (int c = 0; c < 9; c++)
			dr_write(32'h31 + c, 2'd0);
		read_reg(IDX_DR, got);
		check_val("DR check value", got, 32'h0376_E6E7);
		check_val("DR model", got, model_out());
		crc_reset(2'd0, 2'd0, 1'b0);
		for (int n = 0; n < 8; n++)
			dr_write(next_rand(), 2'd2);
		check_reg("DR words", IDX_DR, model_out());
		finish_test("default CRC-32");
	endtask

	task automatic sizes_and_widths();
		for (int ps = 1; ps < 4; ps++)
		begin
			m_poly = next_rand() | 32'h1;
			write_reg(IDX_POL, m_poly);
			m_init = next_rand();
			write_reg(IDX_INIT, m_init);
			crc_reset(2'(ps), 2'd0, 1'b0);
			for (int n = 0; n < 3; n++)
				dr_write(next_rand(), 2'd0);
			check_reg("DR bytes", IDX_DR, model_out());
			for (int n = 0; n < 3; n++)
				dr_write(next_rand(), 2'd1);
			check_reg("DR halfwords", IDX_DR, model_out());
		end
		finish_test("sizes and widths");
	endtask

	task automatic input_output_reversal();
		logic [31:0] got;
		m_init = 32'hFFFF_FFFF;
		m_poly = 32'h04C1_1DB7;
		write_reg(IDX_INIT, m_init);
		write_reg(IDX_POL, m_poly);
		for (int ri = 0; ri < 4; ri++)
		begin
			for (int ro = 0; ro < 2; ro++)
			begin
				crc_reset(2'd0, 2'(ri), 1'(ro));
				dr_write(next_rand(), 2'd2);
				dr_write(next_rand(), 2'd1);
				dr_write(next_rand(), 2'd0);
				check_reg("DR reversed", IDX_DR, model_out());
			end
		end
		// Reflected CRC-32 of "123456789" before the final inversion
		crc_reset(2'd0, 2'd1, 1'b1);
		for (int c = 0; c < 9; c++)
			dr_write(32'h31 + c, 2'd0);
		read_reg(IDX_DR, got);
		check_val("DR reflected check value", got, 32'h340B_C6D9);
		finish_test("reversal");
	endtask

	task automatic back_pressure();
		logic [31:0] new_init;
		int          s0;
		crc_reset(2'd0, 2'd0, 1'b0);
		s0 = stall_cycles;
		for (int n = 0; n < 6; n++)
			dr_write(next_rand(), 2'd2);
		// Only the DR writes count here, the read below stalls on its own
		assert (stall_cycles > s0)
		else
		begin
			$display("Back-to-back DR writes were never held off by the slave");
			test_errs++;
		end
		check_reg("DR after burst", IDX_DR, model_out());
		// Reset armed while a word is in flight, INIT write waits for it
		dr_write(next_rand(), 2'd2);
		crc_reset(2'd0, 2'd0, 1'b0);
		new_init = next_rand();
		write_reg(IDX_INIT, new_init);
		check_reg("DR after pending reset", IDX_DR, model_out());
		check_reg("INIT after pending reset", IDX_INIT, new_init);
		m_init = new_init;
		crc_reset(2'd0, 2'd0, 1'b0);
		check_reg("DR with new INIT", IDX_DR, model_out());
		finish_test("back-pressure");
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		HCLK    = 1'b0;
		HRESETn = 1'b0;
		hsel    = 1'b0;
		haddr   = 32'h0;
		htrans  = HTRANS_IDLE;
		hsize   = 3'd2;
		hwrite  = 1'b0;
		hready  = 1'b1;
		hwdata  = 32'h0;
		repeat (3) @(posedge HCLK);
		HRESETn <= 1'b1;

		reset_values();
		register_access();
		default_crc32();
		sizes_and_widths();
		input_output_reversal();
		back_pressure();

		$display("Tests passed %0d, failed %0d, check errors %0d",
			tests_pass, tests_fail, errors);
		if (errors == 0 && tests_fail == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== design/crc_ahb_top.sv ====
// CRC unit top level
// AHB-Lite slave wrapping host interface, input buffer, config
// registers and the byte-serial CRC engine
`timescale 1ns/100ps

module crc_ahb_top
(
	input  logic             HCLK,
	input  logic             HRESETn,
	input  logic             hsel,
	input  logic [31:0]      haddr,
	input  ahb_pkg::htrans_t htrans,
	input  ahb_pkg::hsize_t  hsize,
	input  logic             hwrite,
	input  logic             hready,
	input  logic [31:0]      hwdata,
	output logic [31:0]      hrdata,
	output logic             hreadyout,
	output logic             hresp
);
	import crc_pkg::*;

	// Host side strobes and data
	logic [31:0] wr_data;
	logic [1:0]  wr_size;
	logic        buf_wr, init_wr, poly_wr, idr_wr, reset_chain;
	crc_cfg_t    cfg;
	// Register and buffer outputs
	logic [31:0] init_value, poly, crc_value;
	logic [7:0]  idr;
	buf_entry_t  entry;
	logic        buf_full, take, engine_busy, reset_pending;

	crc_host_interface u_host (.HCLK, .HRESETn, .hsel, .haddr, .htrans, .hsize, .hwrite,
		.hready, .hwdata, .crc_value, .init_value, .poly, .idr, .buf_full, .engine_busy,
		.reset_pending, .hrdata, .hreadyout, .hresp, .wr_data, .wr_size, .buf_wr,
		.init_wr, .poly_wr, .idr_wr, .reset_chain, .cfg);

	// Data side
	crc_input_buffer u_buf (.HCLK, .HRESETn, .buf_wr, .wr_data, .wr_size, .take,
		.entry, .buf_full);

	// Setup side
	crc_config_regs u_cfg (.HCLK, .HRESETn, .wr_data, .init_wr, .poly_wr, .idr_wr,
		.init_value, .poly, .idr);

	crc_engine u_engine (.HCLK, .HRESETn, .entry, .buf_full, .cfg, .init_value, .poly,
		.reset_chain, .take, .crc_value, .engine_busy, .reset_pending);

endmodule

// ==== design/crc_engine.sv ====
// CRC unit engine
// Takes buffered words, applies input bit reversal and folds the valid
// bytes in MSB first at one byte per clock, with a 32/16/8/7 bit
// programmable polynomial, reset loading from INIT and output reversal
`timescale 1ns/100ps
`include "crc_settings.svh"

module crc_engine
(
	input  logic                HCLK,
	input  logic                HRESETn,
	input  crc_pkg::buf_entry_t entry,
	input  logic                buf_full,
	input  crc_pkg::crc_cfg_t   cfg,
	input  logic [31:0]         init_value,
	input  logic [31:0]         poly,
	input  logic                reset_chain,
	output logic                take,
	output logic [31:0]         crc_value,
	output logic                engine_busy,
	output logic                reset_pending
);
	import crc_pkg::*;

	logic        busy_q;
	logic [1:0]  cnt_q;
	logic [31:0] sh_q;
	logic [31:0] crc_q;
	logic [31:0] rev_data;
	logic [31:0] aligned;
	logic [31:0] wmask;

	// One byte through the shift register, data MSB first
	function automatic logic [31:0] fold_byte(input logic [31:0] crc_in,
		input logic [7:0] data, input logic [31:0] poly_m, input logic [31:0] mask);
		logic [31:0] r;
		logic [31:0] top;
		logic        fb;
		r   = crc_in;
		// Bit w-1 of the active width
		top = mask & ~(mask >> 1);
		for (int i = 7; i >= 0; i--)
		begin
			fb = ((r & top) != 32'h0) ^ data[i];
			r  = (r << 1) & mask;
			if (fb)
				r = r ^ poly_m;
		end
		return r;
	endfunction

	// Width mask from the polynomial size
	always_comb
	begin
		case (cfg.poly_size)
			P16:     wmask = 32'h0000_FFFF;
			P8:      wmask = 32'h0000_00FF;
			P7:      wmask = 32'h0000_007F;
			default: wmask = 32'hFFFF_FFFF;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Input reversal and byte alignment
	////////////////////////////////////////////////////////////
	always_comb
	begin
		logic [4:0] k;
		for (int i = 0; i < 32; i++)
		begin
			k = 5'(i);
			case (cfg.rev_in)
				BYTE:    rev_data[i] = entry.data[{k[4:3], ~k[2:0]}];
				HALF:    rev_data[i] = entry.data[{k[4], ~k[3:0]}];
				WORD:    rev_data[i] = entry.data[~k];
				default: rev_data[i] = entry.data[i];
			endcase
		end
	end

	// Valid low bytes moved to the top so byte 31:24 goes first
	always_comb
	begin
		case (entry.size)
			2'd0:    aligned = {rev_data[7:0], 24'h0};
			2'd1:    aligned = {rev_data[15:0], 16'h0};
			default: aligned = rev_data;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Control and CRC register
	////////////////////////////////////////////////////////////

	// Pending reset goes ahead of a waiting entry
	assign take = buf_full && !busy_q && !reset_pending;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			busy_q        <= 1'b0;
			cnt_q         <= 2'd0;
			crc_q         <= `CRC_INIT_RESET;
			reset_pending <= 1'b0;
		end
		else
		begin
			if (take)
			begin
				busy_q <= 1'b1;
				// Bytes left minus one
				cnt_q  <= (entry.size == 2'd0) ? 2'd0 : (entry.size == 2'd1) ? 2'd1 : 2'd3;
			end
			else if (busy_q)
			begin
				crc_q <= fold_byte(crc_q, sh_q[31:24], poly & wmask, wmask);
				cnt_q <= cnt_q - 2'd1;
				if (cnt_q == 2'd0)
					busy_q <= 1'b0;
			end
			else if (reset_pending)
				crc_q <= init_value & wmask;
			// New request keeps it armed even on the loading edge
			if (reset_chain)
				reset_pending <= 1'b1;
			else if (!busy_q)
				reset_pending <= 1'b0;
		end
	end

	// Byte shifter
	always_ff @(posedge HCLK)
	begin
		if (take)
			sh_q <= aligned;
		else if (busy_q)
			sh_q <= sh_q << 8;
	end

	// DR reads wait for anything still in flight
	assign engine_busy = busy_q || buf_full || reset_pending;
	assign crc_value   = cfg.rev_out ? {<<{crc_q}} : crc_q;

	// Take only from idle, and it always starts a run
	assert property (@(posedge HCLK) disable iff (!HRESETn) take |-> !busy_q ##1 busy_q);

	// Reset load never lands in the middle of a word
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		$fell(reset_pending) |-> $past(!busy_q));

endmodule

// ==== design/crc_config_regs.sv ====
// CRC unit configuration registers
// Initial value, polynomial and the free 8-bit IDR scratch register
`timescale 1ns/100ps
`include "crc_settings.svh"

module crc_config_regs
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic [31:0] wr_data,
	input  logic        init_wr,
	input  logic        poly_wr,
	input  logic        idr_wr,
	output logic [31:0] init_value,
	output logic [31:0] poly,
	output logic [7:0]  idr
);

	////////////////////////////////////////////////////////////
	// INIT
	////////////////////////////////////////////////////////////

	// Loaded into the CRC register on a CR reset
	// Full 32 bits kept, the engine masks to the active width
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			init_value <= `CRC_INIT_RESET;
		else if (init_wr)
			init_value <= wr_data;
	end

	////////////////////////////////////////////////////////////
	// POL
	////////////////////////////////////////////////////////////

	// Generator polynomial without the implicit top bit
	// Defaults to the Ethernet CRC-32 polynomial
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			poly <= `CRC_POLY_RESET;
		else if (poly_wr)
			poly <= wr_data;
	end

	////////////////////////////////////////////////////////////
	// IDR
	////////////////////////////////////////////////////////////

	// General purpose byte for software
	// Not used by the CRC calculation
	// Upper write bits dropped
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			idr <= `CRC_IDR_RESET;
		else if (idr_wr)
			idr <= wr_data[7:0];
	end

endmodule

// ==== design/crc_input_buffer.sv ====
// CRC unit input buffer
// One DR write waits here with its size until the engine takes it
`timescale 1ns/100ps

module crc_input_buffer
(
	input  logic                HCLK,
	input  logic                HRESETn,
	input  logic                buf_wr,
	input  logic [31:0]         wr_data,
	input  logic [1:0]          wr_size,
	input  logic                take,
	output crc_pkg::buf_entry_t entry,
	output logic                buf_full
);

	////////////////////////////////////////////////////////////
	// Full flag
	////////////////////////////////////////////////////////////

	// Write wins over take
	// Host only writes once the previous entry has gone
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			buf_full <= 1'b0;
		end
		else
		begin
			if (buf_wr)
				buf_full <= 1'b1;
			else if (take)
				buf_full <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Payload
	////////////////////////////////////////////////////////////

	// Data and size captured together
	always_ff @(posedge HCLK)
	begin
		if (buf_wr)
		begin
			entry.data <= wr_data;
			entry.size <= wr_size;
		end
	end

	// Host must hold back a DR write while an entry is still waiting
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		!(buf_wr && buf_full && !take));

	// Engine only takes a valid entry, and the flag drops after it
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		take && !buf_wr |-> buf_full ##1 !buf_full);

endmodule

// ==== design/crc_host_interface.sv ====
// CRC unit AHB-Lite host interface
// Samples the address phase, decodes the register map, owns CR,
// muxes read data and holds off the bus on the three stall causes
`timescale 1ns/100ps
`include "crc_settings.svh"

module crc_host_interface
(
	input  logic              HCLK,
	input  logic              HRESETn,
	input  logic              hsel,
	input  logic [31:0]       haddr,
	input  ahb_pkg::htrans_t  htrans,
	input  ahb_pkg::hsize_t   hsize,
	input  logic              hwrite,
	input  logic              hready,
	input  logic [31:0]       hwdata,
	input  logic [31:0]       crc_value,
	input  logic [31:0]       init_value,
	input  logic [31:0]       poly,
	input  logic [7:0]        idr,
	input  logic              buf_full,
	input  logic              engine_busy,
	input  logic              reset_pending,
	output logic [31:0]       hrdata,
	output logic              hreadyout,
	output logic              hresp,
	output logic [31:0]       wr_data,
	output logic [1:0]        wr_size,
	output logic              buf_wr,
	output logic              init_wr,
	output logic              poly_wr,
	output logic              idr_wr,
	output logic              reset_chain,
	output crc_pkg::crc_cfg_t cfg
);
	import ahb_pkg::*;
	import crc_pkg::*;

	ahb_addr_phase_t ap_d;
	ahb_addr_phase_t ap_q;
	crc_cfg_t        cr_q;
	logic            sample_bus;
	logic            active;
	logic            write_act;
	logic            read_act;
	logic            dr_wr_req;
	logic            init_wr_req;
	logic            dr_rd;
	logic            cr_wr;

	////////////////////////////////////////////////////////////
	// Address phase pipeline
	////////////////////////////////////////////////////////////
	always_comb
	begin
		ap_d.sel   = hsel;
		ap_d.write = hwrite;
		ap_d.trans = htrans;
		ap_d.size  = hsize[1:0];
		ap_d.idx   = haddr[4:2];
	end

	// Only advance when the whole bus moves on
	assign sample_bus = hready && hreadyout;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			ap_q <= '0;
		else if (sample_bus)
			ap_q <= ap_d;
	end

	// SEQ falls through as idle, single transfers only
	assign active    = ap_q.sel && (ap_q.trans == HTRANS_NONSEQ);
	assign write_act = active && ap_q.write;
	assign read_act  = active && !ap_q.write;

	////////////////////////////////////////////////////////////
	// Register decode and write strobes
	////////////////////////////////////////////////////////////
	assign dr_wr_req   = write_act && (ap_q.idx == `CRC_OFS_DR);
	assign init_wr_req = write_act && (ap_q.idx == `CRC_OFS_INIT);
	assign poly_wr     = write_act && (ap_q.idx == `CRC_OFS_POL);
	assign idr_wr      = write_act && (ap_q.idx == `CRC_OFS_IDR);
	assign cr_wr       = write_act && (ap_q.idx == `CRC_OFS_CR);
	assign dr_rd       = read_act && (ap_q.idx == `CRC_OFS_DR);

	// Held request lands in the cycle the blocking condition clears
	assign buf_wr  = dr_wr_req && !buf_full;
	assign init_wr = init_wr_req && !reset_pending;

	// Write data comes straight off the bus in the data phase
	assign wr_data = hwdata;
	assign wr_size = ap_q.size;

	// Stall causes
	assign hreadyout = !((dr_wr_req && buf_full) ||
			(dr_rd && engine_busy) ||
			(init_wr_req && reset_pending));

	// Never an error response
	assign hresp = HRESP_OKAY;

	////////////////////////////////////////////////////////////
	// Control register
	////////////////////////////////////////////////////////////
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cr_q <= `CRC_CR_RESET;
		else if (cr_wr)
		begin
			cr_q.poly_size <= poly_size_t'(hwdata[`CRC_CR_PSIZE_LSB +: 2]);
			cr_q.rev_in    <= rev_in_t'(hwdata[`CRC_CR_REVIN_LSB +: 2]);
			cr_q.rev_out   <= hwdata[`CRC_CR_REVOUT_BIT];
		end
	end

	// Reset bit is write-only, pulses for the write cycle
	assign reset_chain = cr_wr && hwdata[`CRC_CR_RST_BIT];
	assign cfg         = cr_q;

	// Read mux, unmapped offsets read zero
	always_comb
	begin
		hrdata = 32'h0;
		case (ap_q.idx)
			`CRC_OFS_DR:   hrdata = crc_value;
			`CRC_OFS_IDR:  hrdata = {24'h0, idr};
			`CRC_OFS_CR:   hrdata = {24'h0, cr_q.rev_out, cr_q.rev_in, cr_q.poly_size, 3'b000};
			`CRC_OFS_INIT: hrdata = init_value;
			`CRC_OFS_POL:  hrdata = poly;
			default:       hrdata = 32'h0;
		endcase
	end

	// Idle data phase never holds the bus
	assert property (@(posedge HCLK) disable iff (!HRESETn) !active |-> hreadyout);

	// A reset request arms the engine next cycle
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		reset_chain |=> reset_pending);

endmodule

// ==== design/crc_pkg.sv ====
// CRC unit types
// Polynomial size and input reversal codes, CR fields and buffer entry
package crc_pkg;

	// Polynomial width selection, CR bits 4:3
	typedef enum logic [1:0]
	{
		P32 = 2'b00,
		P16 = 2'b01,
		P8  = 2'b10,
		P7  = 2'b11
	} poly_size_t;

	// Input bit reversal granularity, CR bits 6:5
	typedef enum logic [1:0]
	{
		NONE = 2'b00,
		BYTE = 2'b01,
		HALF = 2'b10,
		WORD = 2'b11
	} rev_in_t;

	// Configuration held in CR, 5 bits
	typedef struct packed
	{
		poly_size_t poly_size;
		rev_in_t    rev_in;
		logic       rev_out;
	} crc_cfg_t;

	// One DR write
	// Size 0 byte, 1 halfword, 2 word
	typedef struct packed
	{
		logic [31:0] data;
		logic [1:0]  size;
	} buf_entry_t;

endpackage

// ==== design/ahb_pkg.sv ====
// AHB-Lite bus types
// Transfer type, transfer size, response and the sampled address phase
package ahb_pkg;

	// HTRANS encoding
	typedef enum logic [1:0]
	{
		HTRANS_IDLE   = 2'b00,
		HTRANS_BUSY   = 2'b01,
		HTRANS_NONSEQ = 2'b10,
		HTRANS_SEQ    = 2'b11
	} htrans_t;

	// HSIZE, only byte, halfword and word are meaningful here
	typedef logic [2:0] hsize_t;

	// HRESP encoding
	typedef enum logic
	{
		HRESP_OKAY  = 1'b0,
		HRESP_ERROR = 1'b1
	} hresp_t;

	// Address phase as captured for the data phase, 9 bits
	typedef struct packed
	{
		logic       sel;
		logic       write;
		htrans_t    trans;
		logic [1:0] size;
		logic [2:0] idx;
	} ahb_addr_phase_t;

endpackage

// ==== design/crc_settings.svh ====
// CRC unit register map and reset values
// Word offsets decode from address bits 4 to 2
`ifndef CRC_SETTINGS_SVH
`define CRC_SETTINGS_SVH
`define CRC_OFS_DR        3'd0
`define CRC_OFS_IDR       3'd1
`define CRC_OFS_CR        3'd2
`define CRC_OFS_INIT      3'd4
`define CRC_OFS_POL       3'd5
`define CRC_INIT_RESET    32'hFFFF_FFFF
`define CRC_POLY_RESET    32'h04C1_1DB7
`define CRC_IDR_RESET     8'h00
`define CRC_CR_RESET      5'h00
// CR field positions: reset bit, poly size, rev in, rev out
`define CRC_CR_RST_BIT    0
`define CRC_CR_PSIZE_LSB  3
`define CRC_CR_REVIN_LSB  5
`define CRC_CR_REVOUT_BIT 7
`endif
